// File: verilog.f
source/rsp_pkg.sv
source/rsp_cfg_regs.sv
source/rsp_band_detector.sv
source/rsp_delay_line.sv
source/rsp_combination.sv
source/rsp_prep_top.sv
tb/tb_clk_gen.sv
tb/tb_rsp_prep.sv

// File: tb/tb_rsp_prep.sv
`timescale 1ns/1ps

module tb_rsp_prep
  import rsp_pkg::*;
();

  localparam int BURST_WORDS     = 16;
  localparam int GAPPED_WORDS    = 16;
  localparam int REAL_WORDS      = 64;
  localparam int CPLX_WORDS      = 64;
  localparam int CORNER_WORDS    = 48;
  localparam int TOTAL_WORDS     = BURST_WORDS + GAPPED_WORDS + REAL_WORDS +
                                   CPLX_WORDS + CORNER_WORDS;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 10 + 2000;
  localparam int HANDSHAKE_LIMIT = 16;
  localparam int DRAIN_LIMIT     = 4 * PREP_LAT;

  logic                  clk;
  logic                  rst_n;
  logic                  i_cfg_req;
  logic                  i_cfg_we;
  cfg_addr_e             i_cfg_addr;
  logic [CFG_DATA_W-1:0] i_cfg_wdata;
  logic                  o_cfg_ack;
  logic [CFG_DATA_W-1:0] o_cfg_rdata;
  logic [WORD_W-1:0]     i_x;
  logic                  i_x_valid;
  logic [WORD_W-1:0]     o_y;
  logic                  o_y_valid;

  logic [WORD_W-1:0]     exp_q [$];
  int                    err_cnt;
  int                    test_err_base;
  int                    tests_passed;
  int                    tests_failed;

  // Reference model state
  mode_e                 mdl_mode;
  logic [SAMPLE_W-1:0]   mdl_lf_thr;
  logic [SAMPLE_W-1:0]   mdl_hf_thr;
  int                    lf_hist [NUM_LANES][3];
  int                    hf_prev [NUM_LANES];

  tb_clk_gen u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  rsp_prep_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_cfg_req   (i_cfg_req),
    .i_cfg_we    (i_cfg_we),
    .i_cfg_addr  (i_cfg_addr),
    .i_cfg_wdata (i_cfg_wdata),
    .o_cfg_ack   (o_cfg_ack),
    .o_cfg_rdata (o_cfg_rdata),
    .i_x         (i_x),
    .i_x_valid   (i_x_valid),
    .o_y         (o_y),
    .o_y_valid   (o_y_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [WORD_W-1:0] exp,
                             input logic [WORD_W-1:0] act);
    assert (act === exp) else begin
      $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    err_cnt++;
  endtask

  task automatic start_test();
    test_err_base = err_cnt;
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == test_err_base) begin
      tests_passed++;
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s with %0d errors", name, err_cnt - test_err_base);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Host access
  //////////////////////////////////////////////////////////////////////

  task automatic wait_for_ack(input logic level);
    int n;
    n = 0;
    while (o_cfg_ack !== level && n < HANDSHAKE_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (o_cfg_ack !== level) begin
      report_error("o_cfg_ack did not reach the expected level in time");
    end
  endtask

  task automatic cfg_access(input logic we, input cfg_addr_e addr,
                            input logic [CFG_DATA_W-1:0] wdata,
                            output logic [CFG_DATA_W-1:0] rdata);
    i_cfg_req   = 1'b1;
    i_cfg_we    = we;
    i_cfg_addr  = addr;
    i_cfg_wdata = wdata;
    wait_for_ack(1'b1);
    rdata     = o_cfg_rdata;
    i_cfg_req = 1'b0;
    i_cfg_we  = 1'b0;
    wait_for_ack(1'b0);
  endtask

  function automatic logic [CFG_DATA_W-1:0] expected_reg(input cfg_addr_e addr);
    case (addr)
      REG_CTRL:   return {{(CFG_DATA_W-1){1'b0}}, mdl_mode};
      REG_LF_THR: return mdl_lf_thr;
      REG_HF_THR: return mdl_hf_thr;
      default:    return RSP_ID;
    endcase
  endfunction

  task automatic cfg_write(input cfg_addr_e addr, input logic [CFG_DATA_W-1:0] data);
    logic [CFG_DATA_W-1:0] rd;
    case (addr)
      REG_CTRL:   mdl_mode = mode_e'(data[0]);
      REG_LF_THR: mdl_lf_thr = data;
      REG_HF_THR: mdl_hf_thr = data;
      default:    ;
    endcase
    cfg_access(1'b1, addr, data, rd);
    // Ack carries the value just written, or the ID
    check_value("o_cfg_rdata", expected_reg(addr), rd);
  endtask

  task automatic cfg_read(input cfg_addr_e addr, output logic [CFG_DATA_W-1:0] data);
    cfg_access(1'b0, addr, '0, data);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model and stream
  //////////////////////////////////////////////////////////////////////

  function automatic int abs_int(input int v);
    return (v < 0) ? -v : v;
  endfunction

  function automatic int clip(input int v, input int lo, input int hi);
    return (v < lo) ? lo : ((v > hi) ? hi : v);
  endfunction

  task automatic predict_word(input logic [WORD_W-1:0] x, output logic [WORD_W-1:0] y);
    int                   s;
    int                   lf_val [NUM_LANES];
    int                   hf_val [NUM_LANES];
    logic [NUM_LANES-1:0] lf_flag;
    logic [NUM_LANES-1:0] hf_flag;
    logic [NUM_LANES-1:0] keep;
    for (int i = 0; i < NUM_LANES; i++) begin
      s = int'($signed(x[i*SAMPLE_W +: SAMPLE_W]));
      // Four-sample moving sum over 4, floor rounding
      lf_val[i] = (s + lf_hist[i][0] + lf_hist[i][1] + lf_hist[i][2]) >>> 2;
      hf_val[i] = clip(s - hf_prev[i], -32768, 32767);
      lf_hist[i][2] = lf_hist[i][1];
      lf_hist[i][1] = lf_hist[i][0];
      lf_hist[i][0] = s;
      hf_prev[i] = s;
    end
    lf_flag = '0;
    hf_flag = '0;
    if (mdl_mode == MODE_REAL) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        lf_flag[i] = abs_int(lf_val[i]) >= int'(mdl_lf_thr);
        hf_flag[i] = abs_int(hf_val[i]) >= int'(mdl_hf_thr);
      end
    end else begin
      // |I|+|Q| per pair, clipped to 16 bits unsigned
      for (int p = 0; p < NUM_PAIRS; p++) begin
        lf_flag[p] = clip(abs_int(lf_val[2*p]) + abs_int(lf_val[2*p+1]), 0, 65535) >=
                     int'(mdl_lf_thr);
        hf_flag[p] = clip(abs_int(hf_val[2*p]) + abs_int(hf_val[2*p+1]), 0, 65535) >=
                     int'(mdl_hf_thr);
      end
    end
    keep = lf_flag & hf_flag;
    y = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if ((mdl_mode == MODE_REAL && keep[i]) || (mdl_mode == MODE_COMPLEX && keep[i/2])) begin
        y[i*SAMPLE_W +: SAMPLE_W] = x[i*SAMPLE_W +: SAMPLE_W];
      end
    end
  endtask

  function automatic logic [WORD_W-1:0] make_word(input int amp);
    logic [WORD_W-1:0] w;
    for (int i = 0; i < NUM_LANES; i++) begin
      w[i*SAMPLE_W +: SAMPLE_W] = 16'(int'($urandom_range(0, 2 * amp)) - amp);
    end
    return w;
  endfunction

  function automatic logic [WORD_W-1:0] ramp_word(input int step);
    logic [WORD_W-1:0] w;
    for (int i = 0; i < NUM_LANES; i++) begin
      w[i*SAMPLE_W +: SAMPLE_W] = 16'(step * (i + 1));
    end
    return w;
  endfunction

  task automatic send_word(input logic [WORD_W-1:0] x);
    logic [WORD_W-1:0] y;
    predict_word(x, y);
    exp_q.push_back(y);
    i_x       = x;
    i_x_valid = 1'b1;
    @(negedge clk);
    i_x_valid = 1'b0;
  endtask

  task automatic drain_stream();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      report_error("expected output words never appeared on o_y");
      exp_q.delete();
    end
  endtask

  task automatic stream_random_words(input int count, input int thr_max);
    cfg_write(REG_LF_THR, 16'($urandom_range(0, thr_max)));
    cfg_write(REG_HF_THR, 16'($urandom_range(0, thr_max)));
    for (int i = 0; i < count; i++) begin
      send_word(make_word(32767));
    end
    drain_stream();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checkers
  //////////////////////////////////////////////////////////////////////

  // Output words are compared mid-cycle
  always @(negedge clk) begin
    if (rst_n && o_y_valid) begin
      if (exp_q.size() == 0) begin
        report_error("o_y_valid high while no word was expected");
      end else begin
        check_value("o_y", exp_q.pop_front(), o_y);
      end
    end
  end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(o_cfg_ack) |-> $past(i_cfg_req))
    else begin
      $display("ERROR t=%0t o_cfg_ack rose without a request", $time);
      err_cnt++;
    end

  a_ack_drops: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(i_cfg_req) |-> ##2 !o_cfg_ack)
    else begin
      $display("ERROR t=%0t o_cfg_ack still high 2 cycles after req fell", $time);
      err_cnt++;
    end

  a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
    i_x_valid |-> ##PREP_LAT o_y_valid)
    else begin
      $display("[FAIL] t=%0t o_y_valid expected 1 actual 0", $time);
      err_cnt++;
    end

  a_no_extra_valid: assert property (@(posedge clk) disable iff (!rst_n)
    o_y_valid |-> $past(i_x_valid, PREP_LAT))
    else begin
      $display("[FAIL] t=%0t o_y_valid expected 0 actual 1", $time);
      err_cnt++;
    end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles and the run did not finish", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [CFG_DATA_W-1:0] rd;
    logic [CFG_DATA_W-1:0] thr;
    void'($urandom(35398));
    i_cfg_req   = 1'b0;
    i_cfg_we    = 1'b0;
    i_cfg_addr  = REG_CTRL;
    i_cfg_wdata = '0;
    i_x         = '0;
    i_x_valid   = 1'b0;
    mdl_mode    = MODE_REAL;
    mdl_lf_thr  = '0;
    mdl_hf_thr  = '0;
    err_cnt      = 0;
    tests_passed = 0;
    tests_failed = 0;
    wait (rst_n === 1'b1);
    @(negedge clk);

    start_test();
    check_value("o_y_valid", 1'b0, o_y_valid);
    check_value("o_cfg_ack", 1'b0, o_cfg_ack);
    cfg_read(REG_CTRL, rd);
    check_value("o_cfg_rdata", '0, rd);
    cfg_read(REG_ID, rd);
    check_value("o_cfg_rdata", RSP_ID, rd);
    cfg_write(REG_ID, 16'h1234);
    cfg_read(REG_ID, rd);
    check_value("o_cfg_rdata", RSP_ID, rd);
    thr = 16'($urandom_range(0, 16'h3000));
    cfg_write(REG_LF_THR, thr);
    cfg_read(REG_LF_THR, rd);
    check_value("o_cfg_rdata", thr, rd);
    thr = 16'($urandom_range(0, 16'h3000));
    cfg_write(REG_HF_THR, thr);
    cfg_read(REG_HF_THR, rd);
    check_value("o_cfg_rdata", thr, rd);
    finish_test("reset and register access");

    start_test();
    for (int i = 0; i < BURST_WORDS; i++) begin
      send_word(make_word(32767));
    end
    drain_stream();
    for (int i = 0; i < GAPPED_WORDS; i++) begin
      send_word(make_word(32767));
      repeat ($urandom_range(0, 5)) @(negedge clk);
    end
    drain_stream();
    finish_test("latency");

    start_test();
    stream_random_words(REAL_WORDS / 2, 16'h3000);
    stream_random_words(REAL_WORDS / 2, 16'h3000);
    finish_test("real-mode masking");

    start_test();
    cfg_write(REG_CTRL, 16'h0001);
    stream_random_words(CPLX_WORDS / 2, 16'h6000);
    stream_random_words(CPLX_WORDS / 2, 16'h6000);
    finish_test("complex-mode masking");

    start_test();
    cfg_write(REG_CTRL, 16'h0000);
    cfg_write(REG_LF_THR, 16'h0000);
    cfg_write(REG_HF_THR, 16'h0000);
    for (int i = 0; i < 16; i++) begin
      send_word(make_word(32767));
    end
    drain_stream();
    // Small samples cannot reach a full-scale threshold
    cfg_write(REG_LF_THR, 16'hFFFF);
    for (int i = 0; i < 16; i++) begin
      send_word(make_word(100));
    end
    drain_stream();
    cfg_write(REG_LF_THR, 16'h0000);
    cfg_write(REG_HF_THR, 16'h0001);
    for (int i = 0; i < 8; i++) begin
      send_word(ramp_word(291));
    end
    for (int i = 0; i < 8; i++) begin
      send_word(ramp_word(-517));
    end
    drain_stream();
    finish_test("threshold corners");

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 8;

  initial begin
    o_clk   = 1'b0;
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    // Release on a falling edge, away from the sampling edge
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

  always #(HALF_PERIOD) o_clk = ~o_clk;

endmodule

// File: source/rsp_prep_top.sv
`timescale 1ns/1ps

module rsp_prep_top
  import rsp_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_cfg_req,
  input  logic                  i_cfg_we,
  input  cfg_addr_e             i_cfg_addr,
  input  logic [CFG_DATA_W-1:0] i_cfg_wdata,
  output logic                  o_cfg_ack,
  output logic [CFG_DATA_W-1:0] o_cfg_rdata,
  input  logic [WORD_W-1:0]     i_x,
  input  logic                  i_x_valid,
  output logic [WORD_W-1:0]     o_y,
  output logic                  o_y_valid
);

  mode_e                mode;
  logic [SAMPLE_W-1:0]  lf_thr;
  logic [SAMPLE_W-1:0]  hf_thr;
  logic [NUM_LANES-1:0] lf_flags;
  logic [NUM_LANES-1:0] hf_flags;
  logic [NUM_LANES-1:0] hf_flags_al;
  logic [WORD_W-1:0]    x_al;
  logic                 x_al_valid;

  //////////////////////////////////////////////////////////////////////
  // Host registers
  //////////////////////////////////////////////////////////////////////

  rsp_cfg_regs u_cfg_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_cfg_req   (i_cfg_req),
    .i_cfg_we    (i_cfg_we),
    .i_cfg_addr  (i_cfg_addr),
    .i_cfg_wdata (i_cfg_wdata),
    .o_cfg_ack   (o_cfg_ack),
    .o_cfg_rdata (o_cfg_rdata),
    .o_mode      (mode),
    .o_lf_thr    (lf_thr),
    .o_hf_thr    (hf_thr)
  );

  //////////////////////////////////////////////////////////////////////
  // Detectors and alignment
  //////////////////////////////////////////////////////////////////////

  rsp_band_detector #(.BAND(BAND_LF)) u_lf_det (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_x       (i_x),
    .i_x_valid (i_x_valid),
    .i_mode    (mode),
    .i_thr     (lf_thr),
    .o_flags   (lf_flags)
  );

  rsp_band_detector #(.BAND(BAND_HF)) u_hf_det (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_x       (i_x),
    .i_x_valid (i_x_valid),
    .i_mode    (mode),
    .i_thr     (hf_thr),
    .o_flags   (hf_flags)
  );

  // HF is the shorter path
  rsp_delay_line #(.DEPTH(HF_ALIGN), .WIDTH(NUM_LANES)) u_hf_align (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   (hf_flags),
    .o_d   (hf_flags_al)
  );

  rsp_delay_line #(.DEPTH(DATA_ALIGN), .WIDTH(WORD_W+1)) u_data_align (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   ({i_x_valid, i_x}),
    .o_d   ({x_al_valid, x_al})
  );

  rsp_combination u_combination (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_mode     (mode),
    .i_lf_flags (lf_flags),
    .i_hf_flags (hf_flags_al),
    .i_x        (x_al),
    .i_x_valid  (x_al_valid),
    .o_y        (o_y),
    .o_y_valid  (o_y_valid)
  );

endmodule

// File: source/rsp_combination.sv
`timescale 1ns/1ps

module rsp_combination
  import rsp_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  mode_e                i_mode,
  input  logic [NUM_LANES-1:0] i_lf_flags,
  input  logic [NUM_LANES-1:0] i_hf_flags,
  input  logic [WORD_W-1:0]    i_x,
  input  logic                 i_x_valid,
  output logic [WORD_W-1:0]    o_y,
  output logic                 o_y_valid
);

  logic [NUM_LANES-1:0] keep;
  logic [WORD_W-1:0]    y_nxt;

  // A lane survives only if both bands flagged it
  assign keep = i_lf_flags & i_hf_flags;

  always_comb begin
    y_nxt = '0;
    if (i_mode == MODE_REAL) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (keep[i]) begin
          y_nxt[i*SAMPLE_W +: SAMPLE_W] = i_x[i*SAMPLE_W +: SAMPLE_W];
        end
      end
    end else begin
      // I and Q of a pair go together
      for (int p = 0; p < NUM_PAIRS; p++) begin
        if (keep[p]) begin
          y_nxt[p*2*SAMPLE_W +: 2*SAMPLE_W] = i_x[p*2*SAMPLE_W +: 2*SAMPLE_W];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_y       <= '0;
      o_y_valid <= 1'b0;
    end else begin
      o_y       <= y_nxt;
      o_y_valid <= i_x_valid;
    end
  end

endmodule

// File: source/rsp_delay_line.sv
`timescale 1ns/1ps

module rsp_delay_line #(
  parameter int DEPTH = 1,
  parameter int WIDTH = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] i_d,
  output logic [WIDTH-1:0] o_d
);

  logic [WIDTH-1:0] stage [DEPTH];

  // Stage 0 takes the input, the last stage drives the output
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= i_d;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign o_d = stage[DEPTH-1];

endmodule

// File: source/rsp_band_detector.sv
`timescale 1ns/1ps

module rsp_band_detector
  import rsp_pkg::*;
#(
  parameter band_e BAND = BAND_LF
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [WORD_W-1:0]    i_x,
  input  logic                 i_x_valid,
  input  mode_e                i_mode,
  input  logic [SAMPLE_W-1:0]  i_thr,
  output logic [NUM_LANES-1:0] o_flags
);

  logic signed [SAMPLE_W-1:0] x_lane [NUM_LANES];
  logic signed [SAMPLE_W-1:0] filt   [NUM_LANES];

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_split
    assign x_lane[i] = i_x[i*SAMPLE_W +: SAMPLE_W];
  end

  //////////////////////////////////////////////////////////////////////
  // Band filter
  //////////////////////////////////////////////////////////////////////

  if (BAND == BAND_LF) begin : g_lf
    logic signed [SAMPLE_W-1:0] hist    [NUM_LANES][3];
    logic signed [SAMPLE_W:0]   sum_a   [NUM_LANES];
    logic signed [SAMPLE_W:0]   sum_b   [NUM_LANES];
    logic signed [SAMPLE_W+1:0] sum_all [NUM_LANES];

    always_comb begin
      for (int i = 0; i < NUM_LANES; i++) begin
        sum_all[i] = sum_a[i] + sum_b[i];
      end
    end

    // Two adder stages, history moves only on valid words
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        for (int i = 0; i < NUM_LANES; i++) begin
          hist[i][0] <= '0;
          hist[i][1] <= '0;
          hist[i][2] <= '0;
          sum_a[i]   <= '0;
          sum_b[i]   <= '0;
          filt[i]    <= '0;
        end
      end else begin
        for (int i = 0; i < NUM_LANES; i++) begin
          sum_a[i] <= x_lane[i] + hist[i][0];
          sum_b[i] <= hist[i][1] + hist[i][2];
          // Divide by 4, always fits back into one sample
          filt[i]  <= sum_all[i][SAMPLE_W+1:2];
          if (i_x_valid) begin
            hist[i][0] <= x_lane[i];
            hist[i][1] <= hist[i][0];
            hist[i][2] <= hist[i][1];
          end
        end
      end
    end
  end else begin : g_hf
    logic signed [SAMPLE_W-1:0] prev [NUM_LANES];
    logic signed [SAMPLE_W:0]   diff [NUM_LANES];

    always_comb begin
      for (int i = 0; i < NUM_LANES; i++) begin
        diff[i] = x_lane[i] - prev[i];
      end
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        for (int i = 0; i < NUM_LANES; i++) begin
          prev[i] <= '0;
          filt[i] <= '0;
        end
      end else begin
        for (int i = 0; i < NUM_LANES; i++) begin
          // Clip to the signed 16-bit range
          if (diff[i][SAMPLE_W] != diff[i][SAMPLE_W-1]) begin
            filt[i] <= diff[i][SAMPLE_W] ? 16'sh8000 : 16'sh7fff;
          end else begin
            filt[i] <= diff[i][SAMPLE_W-1:0];
          end
          if (i_x_valid) begin
            prev[i] <= x_lane[i];
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Magnitude and threshold compare
  //////////////////////////////////////////////////////////////////////

  logic [SAMPLE_W:0]    mag      [NUM_LANES];
  logic [SAMPLE_W+1:0]  pair_sum [NUM_PAIRS];
  logic [SAMPLE_W-1:0]  pair_mag [NUM_PAIRS];
  logic [NUM_LANES-1:0] flags_nxt;

  always_comb begin
    flags_nxt = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      // 17 bits so that -32768 has a magnitude
      if (filt[i][SAMPLE_W-1]) begin
        mag[i] = ~{1'b1, filt[i]} + 1'b1;
      end else begin
        mag[i] = {1'b0, filt[i]};
      end
    end
    for (int p = 0; p < NUM_PAIRS; p++) begin
      pair_sum[p] = mag[2*p] + mag[2*p+1];
      pair_mag[p] = (|pair_sum[p][SAMPLE_W+1:SAMPLE_W]) ? '1 : pair_sum[p][SAMPLE_W-1:0];
    end
    if (i_mode == MODE_REAL) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        flags_nxt[i] = (mag[i] >= {1'b0, i_thr});
      end
    end else begin
      for (int p = 0; p < NUM_PAIRS; p++) begin
        flags_nxt[p] = (pair_mag[p] >= i_thr);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_flags <= '0;
    end else begin
      o_flags <= flags_nxt;
    end
  end

endmodule

// File: source/rsp_cfg_regs.sv
`timescale 1ns/1ps

module rsp_cfg_regs
  import rsp_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_cfg_req,
  input  logic                  i_cfg_we,
  input  cfg_addr_e             i_cfg_addr,
  input  logic [CFG_DATA_W-1:0] i_cfg_wdata,
  output logic                  o_cfg_ack,
  output logic [CFG_DATA_W-1:0] o_cfg_rdata,
  output mode_e                 o_mode,
  output logic [SAMPLE_W-1:0]   o_lf_thr,
  output logic [SAMPLE_W-1:0]   o_hf_thr
);

  typedef enum logic [1:0] {
    IDLE,
    ACK,
    WAIT_DROP
  } cfg_state_e;

  cfg_state_e            state;
  mode_e                 mode_q;
  logic [SAMPLE_W-1:0]   lf_thr_q;
  logic [SAMPLE_W-1:0]   hf_thr_q;
  mode_e                 mode_nxt;
  logic [SAMPLE_W-1:0]   lf_thr_nxt;
  logic [SAMPLE_W-1:0]   hf_thr_nxt;
  logic [CFG_DATA_W-1:0] rdata_nxt;
  logic                  wr_en;

  // Write only on the first cycle of a request
  assign wr_en = (state == IDLE) && i_cfg_req && i_cfg_we;

  always_comb begin
    mode_nxt   = mode_q;
    lf_thr_nxt = lf_thr_q;
    hf_thr_nxt = hf_thr_q;
    if (wr_en) begin
      case (i_cfg_addr)
        REG_CTRL:   mode_nxt = mode_e'(i_cfg_wdata[0]);
        REG_LF_THR: lf_thr_nxt = i_cfg_wdata[SAMPLE_W-1:0];
        REG_HF_THR: hf_thr_nxt = i_cfg_wdata[SAMPLE_W-1:0];
        default:    ;
      endcase
    end
  end

  // Read mux sees the post-write value, ID is constant
  always_comb begin
    case (i_cfg_addr)
      REG_CTRL:   rdata_nxt = {{(CFG_DATA_W-1){1'b0}}, mode_nxt};
      REG_LF_THR: rdata_nxt = lf_thr_nxt;
      REG_HF_THR: rdata_nxt = hf_thr_nxt;
      default:    rdata_nxt = RSP_ID;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= IDLE;
      o_cfg_ack   <= 1'b0;
      o_cfg_rdata <= '0;
      mode_q      <= MODE_REAL;
      lf_thr_q    <= '0;
      hf_thr_q    <= '0;
    end else begin
      mode_q   <= mode_nxt;
      lf_thr_q <= lf_thr_nxt;
      hf_thr_q <= hf_thr_nxt;
      case (state)
        IDLE: begin
          if (i_cfg_req) begin
            o_cfg_ack   <= 1'b1;
            o_cfg_rdata <= rdata_nxt;
            state       <= ACK;
          end
        end
        // First ack cycle, host has not reacted yet
        ACK: state <= WAIT_DROP;
        WAIT_DROP: begin
          if (!i_cfg_req) begin
            o_cfg_ack <= 1'b0;
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign o_mode   = mode_q;
  assign o_lf_thr = lf_thr_q;
  assign o_hf_thr = hf_thr_q;

endmodule

// File: source/rsp_pkg.sv
package rsp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Datapath geometry
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_LANES = 8;
  localparam int NUM_PAIRS = NUM_LANES / 2;
  localparam int SAMPLE_W  = 16;
  localparam int WORD_W    = NUM_LANES * SAMPLE_W;

  // Pipeline depths, HF path is padded up to the LF path
  localparam int LF_LAT     = 3;
  localparam int HF_LAT     = 2;
  localparam int HF_ALIGN   = LF_LAT - HF_LAT;
  localparam int DATA_ALIGN = LF_LAT;
  localparam int PREP_LAT   = DATA_ALIGN + 1;

  //////////////////////////////////////////////////////////////////////
  // Host register map
  //////////////////////////////////////////////////////////////////////

  localparam int CFG_DATA_W = 16;

  localparam logic [CFG_DATA_W-1:0] RSP_ID = 16'h5250;

  typedef enum logic [1:0] {
    REG_CTRL   = 2'd0,
    REG_LF_THR = 2'd1,
    REG_HF_THR = 2'd2,
    REG_ID     = 2'd3
  } cfg_addr_e;

  typedef enum logic {
    MODE_REAL    = 1'b0,
    MODE_COMPLEX = 1'b1
  } mode_e;

  typedef enum logic {
    BAND_LF = 1'b0,
    BAND_HF = 1'b1
  } band_e;

endpackage
